//--- sim/axi_slave_model.sv
`default_nettype none

module axi_slave_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    aw_hold,  // back-pressure bits from the testbench
    input  logic                    w_hold,
    input  mmio_bus_pkg::addr_t     araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output mmio_bus_pkg::data_t     rdata,
    output logic                    rlast,
    output logic                    rvalid,
    input  logic                    rready,
    input  mmio_bus_pkg::addr_t     awaddr,
    input  mmio_bus_pkg::axi_len_t  awlen,
    input  mmio_bus_pkg::axi_size_t awsize,
    input  logic                    awvalid,
    output logic                    awready,
    input  mmio_bus_pkg::data_t     wdata,
    input  mmio_bus_pkg::strb_t     wstrb,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    output logic                    log_valid,
    output mmio_bus_pkg::addr_t     log_addr,
    output mmio_bus_pkg::axi_size_t log_size,
    output mmio_bus_pkg::axi_len_t  log_len,
    output logic                    log_last,
    output mmio_bus_pkg::strb_t     log_strb,
    output mmio_bus_pkg::data_t     log_data
);
    timeunit 1ns;
    timeprecision 1ps;

    import mmio_bus_pkg::*;

    logic aw_got;  // aw half of the current write seen
    logic w_got;

    assign awready = !aw_hold;
    assign wready  = !w_hold;
    assign arready = !aw_hold;
    assign rlast   = rvalid;  // single beat reads

    initial begin
        aw_got    = 1'b0;
        w_got     = 1'b0;
        rvalid    = 1'b0;
        bvalid    = 1'b0;
        log_valid = 1'b0;
        rdata     = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            rvalid    <= 1'b0;
            bvalid    <= 1'b0;
            log_valid <= 1'b0;
        end else begin
            log_valid <= 1'b0;
            bvalid    <= log_valid;
            if (awvalid && awready) begin
                aw_got   <= 1'b1;
                log_addr <= awaddr;
                log_size <= awsize;
                log_len  <= awlen;
            end
            if (wvalid && wready) begin
                w_got    <= 1'b1;
                log_strb <= wstrb;
                log_data <= wdata;
                log_last <= wlast;
            end
            // both halves in, one record out
            if ((aw_got || (awvalid && awready)) && (w_got || (wvalid && wready))) begin
                aw_got    <= 1'b0;
                w_got     <= 1'b0;
                log_valid <= 1'b1;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rdata  <= araddr ^ 32'h5a5a_a5a5;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/mmio_access_unit_tb.sv
`default_nettype none

module mmio_access_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mmio_bus_pkg::*;
    import mmio_ctrl_pkg::*;

    localparam int REC_W   = 80;  // addr, size, len, last, strb, data
    localparam int TIMEOUT = 400;

    logic clk;
    logic rst;
    logic stall_m;
    logic dstall;
    logic mem_en;
    logic mem_write;
    addr_t mem_pa;
    size_t mem_size;
    strb_t mem_wmask;
    data_t mem_wdata;
    data_t mem_rdata;
    addr_t araddr;
    axi_len_t arlen;
    axi_size_t arsize;
    logic arvalid;
    logic arready;
    data_t rdata;
    logic rlast;
    logic rvalid;
    logic rready;
    addr_t awaddr;
    axi_len_t awlen;
    axi_size_t awsize;
    logic awvalid;
    logic awready;
    data_t wdata;
    strb_t wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic aw_hold;
    logic w_hold;
    logic log_valid;
    addr_t log_addr;
    axi_size_t log_size;
    axi_len_t log_len;
    logic log_last;
    strb_t log_strb;
    data_t log_data;

    logic [15:0] stim_lfsr;
    logic [15:0] bp_lfsr;
    logic bp_random;
    int bp_full;  // cycles of full back-pressure left
    logic [REC_W-1:0] expect_q[$];
    int accepted = 0;
    int logged = 0;
    int ar_seen = 0;

    mmio_access_unit i_dut (.*);

    axi_slave_model i_slave (.*);

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // the bus record a posted write must produce
    function automatic logic [REC_W-1:0] expected_write(input addr_t a, input size_t s,
                                                        input strb_t m, input data_t d);
        axi_size_t sz;
        sz = {1'b0, s};
        return {a, sz, axi_len_t'(0), 1'b1, m, d};
    endfunction

    function automatic data_t read_word(input addr_t a);
        return a ^ 32'h5a5a_a5a5;
    endfunction

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_size(input string name, input axi_size_t got, input axi_size_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_len(input string name, input axi_len_t got, input axi_len_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_state(input string name, input access_state_e got,
                               input access_state_e exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // ready patterns for the slave
    always @(posedge clk) begin
        if (bp_full > 0) begin
            bp_full <= bp_full - 1;
            aw_hold <= 1'b1;
            w_hold  <= 1'b1;
        end else if (bp_random) begin
            bp_lfsr = lfsr_next(bp_lfsr);
            aw_hold <= bp_lfsr[0];
            bp_lfsr = lfsr_next(bp_lfsr);
            w_hold  <= bp_lfsr[0];
        end else begin
            aw_hold <= 1'b0;
            w_hold  <= 1'b0;
        end
    end

    always @(posedge clk) begin
        logic [REC_W-1:0] exp_rec;
        if (log_valid) begin
            if (expect_q.size() == 0) begin
                fail_plain("a write reached the bus with no request behind it");
            end
            exp_rec = expect_q.pop_front();
            check_addr("awaddr", log_addr, exp_rec[79:48]);
            check_size("awsize", log_size, exp_rec[47:45]);
            check_len("awlen", log_len, exp_rec[44:37]);
            check_bit("wlast", log_last, exp_rec[36]);
            check_strb("wstrb", log_strb, exp_rec[35:32]);
            check_data("wdata", log_data, exp_rec[31:0]);
            logged++;
        end
        if (arvalid && arready) begin
            ar_seen++;
        end
    end

    // drives one request and waits until the pipeline can move on
    task automatic run_request(input logic wr, input addr_t a, input size_t s, input strb_t m,
                               input data_t d, input int hold, output logic stalled);
        int cyc;
        logic done;
        @(posedge clk);
        mem_en    <= 1'b1;
        mem_write <= wr;
        mem_pa    <= a;
        mem_size  <= s;
        mem_wmask <= m;
        mem_wdata <= d;
        stall_m   <= (hold > 0);
        cyc  = 0;
        done = 1'b0;
        @(negedge clk);
        stalled = dstall;
        if (wr) begin
            expect_q.push_back(expected_write(a, s, m, d));
            accepted++;
        end
        while (!done) begin
            if (arvalid) begin
                if (logged != accepted) begin
                    fail_plain("read went out before the earlier writes had finished");
                end
                check_addr("araddr", araddr, a);
                check_len("arlen", arlen, axi_len_t'(0));  // single beat
                check_size("arsize", arsize, {1'b0, s});
            end
            if (!wr && !dstall) begin
                check_state("state", i_dut.i_fsm.state, SAVE_RESULT);
                check_data("mem_rdata", mem_rdata, read_word(a));
                check_bit("arvalid", arvalid, 1'b0);
            end
            if (!dstall && !stall_m) begin
                done = 1'b1;
            end else begin
                cyc++;
                if (cyc > TIMEOUT) begin
                    fail_plain("timeout waiting for a request to complete");
                end
                @(posedge clk);
                if (cyc >= hold) begin
                    stall_m <= 1'b0;
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic random_write(input int hold, output logic stalled);
        addr_t a;
        size_t s;
        strb_t m;
        data_t d;
        a = take_bits(32);
        s = size_t'(take_bits(2));
        m = strb_t'(take_bits(4));
        d = take_bits(32);
        run_request(1'b1, a, s, m, d, hold, stalled);
    endtask

    task automatic go_idle();
        @(posedge clk);
        mem_en    <= 1'b0;
        mem_write <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_drained();
        int cyc;
        cyc = 0;
        while (logged != accepted) begin
            cyc++;
            if (cyc > TIMEOUT) begin
                fail_plain("timeout waiting for posted writes to reach the bus");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        logic st;
        addr_t ra;
        int ar_before;
        clk       = 1'b0;
        rst       = 1'b1;
        stall_m   = 1'b0;
        mem_en    = 1'b0;
        mem_write = 1'b0;
        mem_pa    = '0;
        mem_size  = '0;
        mem_wmask = '0;
        mem_wdata = '0;
        aw_hold   = 1'b0;
        w_hold    = 1'b0;
        bp_random = 1'b0;
        bp_full   = 0;
        stim_lfsr = 16'd60288;
        bp_lfsr   = 16'd60288;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        repeat (20) begin
            @(negedge clk);
            check_bit("dstall", dstall, 1'b0);
            check_bit("arvalid", arvalid, 1'b0);
            check_bit("rready", rready, 1'b0);
            check_bit("awvalid", awvalid, 1'b0);
            check_bit("wvalid", wvalid, 1'b0);
            check_bit("bready", bready, 1'b1);
        end
        check_state("state", i_dut.i_fsm.state, IDLE);

        random_write(0, st);
        if (st) begin
            fail_plain("single write stalled in its request cycle");
        end
        go_idle();
        wait_drained();

        bp_random = 1'b1;
        repeat (60) random_write(0, st);
        go_idle();
        wait_drained();

        // one write in flight, then seven fill the buffer
        bp_full = 40;
        for (int i = 0; i < 9; i++) begin
            random_write(0, st);
            if (i < 8 && st) begin
                fail_plain("write stalled before the store buffer was full");
            end
            if (i == 8 && !st) begin
                fail_plain("write did not stall with the store buffer full");
            end
        end

        repeat (5) random_write(0, st);
        ra = take_bits(32);
        ar_before = ar_seen;
        run_request(1'b0, ra, 2'd2, 4'h0, '0, 0, st);
        go_idle();
        if (ar_seen != ar_before + 1) begin
            fail_plain("read did not make exactly one address handshake");
        end

        wait_drained();
        bp_random = 1'b0;
        random_write(6, st);
        go_idle();
        wait_drained();
        repeat (20) @(negedge clk);

        ra = take_bits(32);
        ar_before = ar_seen;
        run_request(1'b0, ra, 2'd1, 4'h0, '0, 12, st);  // result held under stall_m
        go_idle();
        if (ar_seen != ar_before + 1) begin
            fail_plain("held read made a second address handshake");
        end

        repeat (10) @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/mmio_bus_pkg.sv
verilog/mmio_ctrl_pkg.sv
verilog/store_buffer_ptrs.sv
verilog/store_buffer_mem.sv
verilog/axi_write_issuer.sv
verilog/mmio_access_fsm.sv
verilog/mmio_access_unit.sv
sim/axi_slave_model.sv
sim/mmio_access_unit_tb.sv

//--- verilog/axi_write_issuer.sv
`default_nettype none

module axi_write_issuer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sb_pending,
    input  mmio_bus_pkg::addr_t     ent_addr,
    input  mmio_bus_pkg::size_t     ent_size,
    input  mmio_bus_pkg::strb_t     ent_strb,
    input  mmio_bus_pkg::data_t     ent_data,
    input  logic                    awready,
    input  logic                    wready,
    output logic                    pop,
    output logic                    sb_busy,
    output logic                    awvalid,
    output logic                    wvalid,
    output logic                    wlast,
    output mmio_bus_pkg::addr_t     awaddr,
    output mmio_bus_pkg::axi_len_t  awlen,
    output mmio_bus_pkg::axi_size_t awsize,
    output mmio_bus_pkg::data_t     wdata,
    output mmio_bus_pkg::strb_t     wstrb
);

    import mmio_bus_pkg::*;

    logic in_flight;
    logic aw_done;
    logic w_done;

    logic aw_fire;
    logic w_fire;
    logic entry_done;
    logic load;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // both channels finished, either earlier or now
    assign entry_done = in_flight && (aw_done || aw_fire) && (w_done || w_fire);

    // next entry only once the channel is free again
    assign load = !in_flight && sb_pending;
    assign pop  = load;

    assign sb_busy = sb_pending || in_flight;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            wlast     <= 1'b0;
        end else if (load) begin
            in_flight <= 1'b1;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            awvalid   <= 1'b1;
            wvalid    <= 1'b1;
            wlast     <= 1'b1;  // single beat per write
        end else if (in_flight) begin
            if (aw_fire) begin
                awvalid <= 1'b0;
                aw_done <= 1'b1;
            end
            if (w_fire) begin
                wvalid <= 1'b0;
                wlast  <= 1'b0;
                w_done <= 1'b1;
            end
            if (entry_done) begin
                in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            awaddr <= ent_addr;
            awlen  <= axi_len_t'(0);
            awsize <= {1'b0, ent_size};
            wdata  <= ent_data;
            wstrb  <= ent_strb;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mmio_access_fsm.sv
`default_nettype none

module mmio_access_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall_m,
    input  logic                    mem_en,
    input  logic                    mem_write,
    input  mmio_bus_pkg::addr_t     mem_pa,
    input  mmio_bus_pkg::size_t     mem_size,
    input  logic                    sb_full,
    input  logic                    sb_busy,
    input  logic                    arready,
    input  logic                    rvalid,
    input  mmio_bus_pkg::data_t     rdata,
    output logic                    dstall,
    output logic                    push,
    output logic                    arvalid,
    output logic                    rready,
    output mmio_bus_pkg::addr_t     araddr,
    output mmio_bus_pkg::axi_len_t  arlen,
    output mmio_bus_pkg::axi_size_t arsize,
    output mmio_bus_pkg::data_t     mem_rdata
);

    import mmio_bus_pkg::*;
    import mmio_ctrl_pkg::*;

    access_state_e state;
    logic          write_saved;  // current write already in the buffer
    data_t         rd_result;

    logic rd_req;
    logic wr_req;
    logic rd_issue;

    assign rd_req = mem_en && !mem_write;
    assign wr_req = mem_en && mem_write;

    // reads wait for the store buffer to drain
    assign rd_issue = (state == IDLE) && rd_req && !sb_busy;

    assign push = (state == IDLE) && wr_req && !sb_full && !write_saved;

    always_comb begin
        if (state == IDLE) begin
            dstall = rd_req || (wr_req && sb_full && !write_saved);
        end else begin
            dstall = (state != SAVE_RESULT);
        end
    end

    assign mem_rdata = rd_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            write_saved <= 1'b0;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_req && !dstall && !stall_m) begin
                        write_saved <= 1'b0;  // request retires
                    end else if (push) begin
                        write_saved <= 1'b1;
                    end
                    if (rd_issue) begin
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        state   <= UNCACHED_READ;
                    end
                end
                UNCACHED_READ: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid) begin
                        rready <= 1'b0;
                        state  <= SAVE_RESULT;
                    end
                end
                SAVE_RESULT: begin
                    if (!stall_m) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            araddr <= mem_pa;
            arlen  <= axi_len_t'(0);  // single beat
            arsize <= {1'b0, mem_size};
        end
        if ((state == UNCACHED_READ) && rvalid) begin
            rd_result <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mmio_access_unit.sv
`default_nettype none

`include "mmio_settings.svh"

module mmio_access_unit (
    input  logic                       clk,
    input  logic                       rst,
    // cpu side
    input  logic                       stall_m,
    output logic                       dstall,
    input  logic                       mem_en,
    input  logic                       mem_write,
    input  logic [`MMIO_ADDR_W-1:0]    mem_pa,
    input  logic [1:0]                 mem_size,
    input  logic [`MMIO_DATA_W/8-1:0]  mem_wmask,
    input  logic [`MMIO_DATA_W-1:0]    mem_wdata,
    output logic [`MMIO_DATA_W-1:0]    mem_rdata,
    // axi read
    output logic [`MMIO_ADDR_W-1:0]    araddr,
    output logic [7:0]                 arlen,
    output logic [2:0]                 arsize,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [`MMIO_DATA_W-1:0]    rdata,
    input  logic                       rlast,   // single beat, not needed
    input  logic                       rvalid,
    output logic                       rready,
    // axi write
    output logic [`MMIO_ADDR_W-1:0]    awaddr,
    output logic [7:0]                 awlen,
    output logic [2:0]                 awsize,
    output logic                       awvalid,
    input  logic                       awready,
    output logic [`MMIO_DATA_W-1:0]    wdata,
    output logic [`MMIO_DATA_W/8-1:0]  wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,
    // axi response, posted writes ignore it
    input  logic                       bvalid,
    output logic                       bready
);

    logic                      push;
    logic                      pop;
    logic                      sb_full;
    logic                      sb_pending;
    logic                      sb_busy;
    logic [`MMIO_SB_PTR_W-1:0] head;
    logic [`MMIO_SB_PTR_W-1:0] tail;

    // head entry of the store buffer
    logic [`MMIO_ADDR_W-1:0]   ent_addr;
    logic [1:0]                ent_size;
    logic [`MMIO_DATA_W/8-1:0] ent_strb;
    logic [`MMIO_DATA_W-1:0]   ent_data;

    assign bready = 1'b1;

    mmio_access_fsm i_fsm (
        .clk       (clk),
        .rst       (rst),
        .stall_m   (stall_m),
        .mem_en    (mem_en),
        .mem_write (mem_write),
        .mem_pa    (mem_pa),
        .mem_size  (mem_size),
        .sb_full   (sb_full),
        .sb_busy   (sb_busy),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .dstall    (dstall),
        .push      (push),
        .arvalid   (arvalid),
        .rready    (rready),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .mem_rdata (mem_rdata)
    );

    store_buffer_ptrs i_ptrs (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .head       (head),
        .tail       (tail),
        .sb_full    (sb_full),
        .sb_pending (sb_pending)
    );

    store_buffer_mem i_mem (
        .clk      (clk),
        .push     (push),
        .tail     (tail),
        .head     (head),
        .in_addr  (mem_pa),
        .in_size  (mem_size),
        .in_strb  (mem_wmask),
        .in_data  (mem_wdata),
        .out_addr (ent_addr),
        .out_size (ent_size),
        .out_strb (ent_strb),
        .out_data (ent_data)
    );

    axi_write_issuer i_issuer (
        .clk        (clk),
        .rst        (rst),
        .sb_pending (sb_pending),
        .ent_addr   (ent_addr),
        .ent_size   (ent_size),
        .ent_strb   (ent_strb),
        .ent_data   (ent_data),
        .awready    (awready),
        .wready     (wready),
        .pop        (pop),
        .sb_busy    (sb_busy),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .wlast      (wlast),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awsize     (awsize),
        .wdata      (wdata),
        .wstrb      (wstrb)
    );

endmodule

`default_nettype wire

//--- verilog/mmio_bus_pkg.sv
`default_nettype none

`include "mmio_settings.svh"

package mmio_bus_pkg;

    typedef logic [`MMIO_ADDR_W-1:0]   addr_t;  // byte address
    typedef logic [`MMIO_DATA_W-1:0]   data_t;
    typedef logic [`MMIO_DATA_W/8-1:0] strb_t;  // one bit per byte lane

    // cpu access size, log2 of bytes
    typedef logic [1:0] size_t;

    // axi fields
    typedef logic [2:0] axi_size_t;
    typedef logic [7:0] axi_len_t;

endpackage

`default_nettype wire

//--- verilog/mmio_ctrl_pkg.sv
`default_nettype none

`include "mmio_settings.svh"

package mmio_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        UNCACHED_READ,  // ar issued, waiting for r
        SAVE_RESULT     // result held until pipeline moves
    } access_state_e;

    typedef logic [`MMIO_SB_PTR_W-1:0] sb_ptr_t;

endpackage

`default_nettype wire

//--- verilog/mmio_settings.svh
`ifndef MMIO_SETTINGS_SVH
`define MMIO_SETTINGS_SVH

// bus widths
`define MMIO_ADDR_W 32
`define MMIO_DATA_W 32

// store buffer, depth must stay a power of two
`define MMIO_SB_DEPTH 8
`define MMIO_SB_PTR_W 3

`endif

//--- verilog/store_buffer_mem.sv
`default_nettype none

`include "mmio_settings.svh"

module store_buffer_mem (
    input  logic                   clk,
    input  logic                   push,
    input  mmio_ctrl_pkg::sb_ptr_t tail,
    input  mmio_ctrl_pkg::sb_ptr_t head,
    input  mmio_bus_pkg::addr_t    in_addr,
    input  mmio_bus_pkg::size_t    in_size,
    input  mmio_bus_pkg::strb_t    in_strb,
    input  mmio_bus_pkg::data_t    in_data,
    output mmio_bus_pkg::addr_t    out_addr,
    output mmio_bus_pkg::size_t    out_size,
    output mmio_bus_pkg::strb_t    out_strb,
    output mmio_bus_pkg::data_t    out_data
);

    import mmio_bus_pkg::*;

    addr_t addr_q [`MMIO_SB_DEPTH];
    size_t size_q [`MMIO_SB_DEPTH];
    strb_t strb_q [`MMIO_SB_DEPTH];
    data_t data_q [`MMIO_SB_DEPTH];  // lanes as on the w channel

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[tail] <= in_addr;
            size_q[tail] <= in_size;
            strb_q[tail] <= in_strb;
            data_q[tail] <= in_data;
        end
    end

    // head entry, read without a register
    assign out_addr = addr_q[head];
    assign out_size = size_q[head];
    assign out_strb = strb_q[head];
    assign out_data = data_q[head];

endmodule

`default_nettype wire

//--- verilog/store_buffer_ptrs.sv
`default_nettype none

module store_buffer_ptrs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  logic                   pop,
    output mmio_ctrl_pkg::sb_ptr_t head,
    output mmio_ctrl_pkg::sb_ptr_t tail,
    output logic                   sb_full,
    output logic                   sb_pending
);

    import mmio_ctrl_pkg::*;

    sb_ptr_t tail_next;

    assign tail_next = tail + sb_ptr_t'(1);

    // one slot stays free so full and empty differ
    assign sb_full    = (tail_next == head);
    assign sb_pending = (head != tail);

    // next free entry
    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
        end else if (push) begin
            tail <= tail_next;
        end
    end

    // oldest entry
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
        end else if (pop) begin
            head <= head + sb_ptr_t'(1);  // wraps at depth
        end
    end

endmodule

`default_nettype wire
